//--- project.f
hw/hsio_pkg.sv
hw/lane_phase_fifo.sv
hw/hsio_tx_path.sv
hw/pma_lane_model.sv
hw/hsio_rx_path.sv
hw/analog_reconfig_ctrl.sv
hw/hsio_bank.sv
verification/hsio_clock_gen.sv
verification/hsio_bank_properties.sv
verification/hsio_bank_tb.sv

//--- Bender.yml
package:
  name: hsio_bank

sources:
  - files:
      - hw/hsio_pkg.sv
      - hw/lane_phase_fifo.sv
      - hw/hsio_tx_path.sv
      - hw/pma_lane_model.sv
      - hw/hsio_rx_path.sv
      - hw/analog_reconfig_ctrl.sv
      - hw/hsio_bank.sv
  - target: test
    files:
      - verification/hsio_clock_gen.sv
      - verification/hsio_bank_properties.sv
      - verification/hsio_bank_tb.sv

//--- verification/hsio_bank_tb.sv
`timescale 1ns/10ps

module hsio_bank_tb;

  import hsio_pkg::*;

  localparam int RECO_WAIT  = 64;
  localparam int PMA_BUSY   = 16;
  localparam int STREAM_LEN = 60;                                   // words per stream test
  localparam int RECO_LEN   = 2 * RECO_WAIT + 2 * PMA_BUSY + 16;    // write plus read-back
  localparam int MAX_CYCLES = 8 + 3 * STREAM_LEN + 3 * RECO_LEN + 100;

  typedef lane_word_t [LANES-1:0] bank_word_t;

  logic         clk_in;
  logic         tx_lane_arst;
  logic         tx_lane_arst_early;
  bank_word_t   tx_datain;
  bank_word_t   rx_lane_data;
  logic         serial_loopback;
  logic         tx_error_inject;
  logic         wr_analog;
  logic         rd_analog;
  analog_word_t new_analog_params;
  bank_word_t   tx_lane_data;
  bank_word_t   rx_dataout;
  logic         reco_busy;
  analog_word_t analog_params;

  bank_word_t exp_tx [0:MAX_CYCLES];  // expected tx_lane_data indexed by input cycle
  bank_word_t src_rx [0:MAX_CYCLES];  // expected rx_words in serial order
  bank_word_t marker_word;
  int   n        = 0;   // negedge count
  int   marker_n = -1;  // cycle the marker sat on tx_datain
  int   tx_lat   = -1;
  int   rx_lat   = -1;
  int   cycles   = 0;
  int   checks   = 0;
  int   errs     = 0;
  int   tx_errs  = 0;
  logic inj_d1   = 1'b0;
  logic inj_d2   = 1'b0;
  wire  [2*LANES:0] prop_failed;  // one flag per bound checker

  hsio_clock_gen #(.period_ns(20.0), .rst_cycles(8)) u_clk (
    .clk_in, .tx_lane_arst, .tx_lane_arst_early
  );

  hsio_bank #(.lanes(LANES), .reco_wait_cycles(RECO_WAIT), .pma_busy_cycles(PMA_BUSY)) dut0 (
    .clk_in, .tx_lane_arst, .tx_lane_arst_early, .tx_datain, .rx_lane_data,
    .serial_loopback, .tx_error_inject, .wr_analog, .rd_analog, .new_analog_params,
    .tx_lane_data, .rx_dataout, .reco_busy, .analog_params
  );

  bind analog_reconfig_ctrl hsio_bank_properties u_reco_props (
    .clk_in, .tx_lane_arst, .reco_write, .reco_read,
    .write_window (state == hsio_pkg::write_wait),
    .read_window  (state == hsio_pkg::read_wait),
    .purge        (1'b0),
    .q            ('0)
  );

  bind lane_phase_fifo hsio_bank_properties u_fifo_props (
    .clk_in, .tx_lane_arst, .reco_write(1'b0), .reco_read(1'b0),
    .write_window(1'b0), .read_window(1'b0), .purge, .q
  );

  // failure flags of the bound checkers
  assign prop_failed[2*LANES] = (dut0.u_reco.u_reco_props.fail_cnt != 0);

  for (genvar l = 0; l < LANES; l++) begin : g_prop_tap
    assign prop_failed[l]       = (dut0.g_txf[l].u_txf.u_fifo_props.fail_cnt != 0);
    assign prop_failed[LANES+l] = (dut0.u_rx_path.g_rxf[l].u_rxf.u_fifo_props.fail_cnt != 0);
  end

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////
  function automatic lane_word_t reverse_bits(input lane_word_t w);
    lane_word_t r;
    for (int b = 0; b < WORD_LEN; b++) begin
      r[WORD_LEN-1-b] = w[b];
    end
    return r;
  endfunction

  function automatic bank_word_t reverse_lanes(input bank_word_t w);
    bank_word_t r;
    for (int l = 0; l < LANES; l++) begin
      r[l] = reverse_bits(w[l]);
    end
    return r;
  endfunction

  // injected error lands on bit 0 of every lane
  function automatic bank_word_t apply_flip(input bank_word_t w, input logic flip);
    bank_word_t r;
    for (int l = 0; l < LANES; l++) begin
      r[l] = {w[l][WORD_LEN-1:1], w[l][0] ^ flip};
    end
    return r;
  endfunction

  // fields packed eq, dc gain, three taps and swing from the msb down
  function automatic analog_word_t pack_setting(input logic [3:0] eq, input logic [2:0] dc,
      input logic [4:0] p0, input logic [4:0] p1, input logic [4:0] p2, input logic [2:0] vod);
    return {eq, dc, p0, p1, p2, vod};
  endfunction

  ////////////////////////////////////////////////////////////
  // compare process sampling between edges
  ////////////////////////////////////////////////////////////
  always @(negedge clk_in) begin
    if (n <= MAX_CYCLES) begin
      exp_tx[n] = apply_flip(reverse_lanes(tx_datain), inj_d1 & ~inj_d2);  // edge one cycle back
      inj_d2 = inj_d1;
      inj_d1 = tx_error_inject;
      if (marker_n < 0 && tx_datain == marker_word) marker_n = n;
      if (marker_n >= 0 && tx_lat < 0 && tx_lane_data == exp_tx[marker_n]) tx_lat = n - marker_n;
      if (tx_lat >= 0) src_rx[n] = serial_loopback ? exp_tx[n - tx_lat] : rx_lane_data;
      if (tx_lat >= 0 && rx_lat < 0 && rx_dataout == marker_word) rx_lat = n - marker_n;
      if (tx_lat >= 0 && n >= marker_n + tx_lat) begin
        checks++;
        if (tx_lane_data !== exp_tx[n - tx_lat]) begin
          errs++;
          tx_errs++;
          $display("[FAIL] %0d ns tx_lane_data %h, expected %h", $time, tx_lane_data,
                   exp_tx[n - tx_lat]);
        end
      end
      if (rx_lat >= 0 && n >= marker_n + rx_lat) begin
        checks++;
        if (rx_dataout !== reverse_lanes(src_rx[n - rx_lat + tx_lat])) begin
          errs++;
          $display("[FAIL] %0d ns rx_dataout %h, expected %h", $time, rx_dataout,
                   reverse_lanes(src_rx[n - rx_lat + tx_lat]));
        end
      end
      n++;
    end
  end

  // watchdog
  always @(posedge clk_in) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////
  task automatic drive_stream(input int len, input logic loop_on, input logic inject);
    for (int i = 0; i < len; i++) begin
      @(posedge clk_in);
      serial_loopback <= loop_on;
      tx_error_inject <= inject;
      for (int l = 0; l < LANES; l++) begin
        tx_datain[l]    <= lane_word_t'($urandom);
        rx_lane_data[l] <= lane_word_t'($urandom);
      end
    end
  endtask

  task automatic wait_busy(input logic level);
    while (reco_busy !== level) @(negedge clk_in);
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("test %-14s %0d errors", name, errs - errs_before);
  endtask

  initial begin
    int           e0;
    analog_word_t setting;
    void'($urandom(32'h9563_116f));
    tx_datain         = '0;
    rx_lane_data      = '0;
    serial_loopback   = 1'b1;
    tx_error_inject   = 1'b0;
    wr_analog         = 1'b0;
    rd_analog         = 1'b0;
    new_analog_params = '0;
    for (int l = 0; l < LANES; l++) begin
      marker_word[l] = 20'hc3a5e + lane_word_t'(l);  // distinct per lane
    end
    @(negedge tx_lane_arst);
    @(negedge clk_in);

    e0 = errs;                                        // outputs idle after reset
    checks++;
    if (tx_lane_data !== '0 || rx_dataout !== '0) begin
      errs++;
      $display("[FAIL] %0d ns lane outputs not zero after reset", $time);
    end
    checks++;
    if (analog_params !== '0 || reco_busy !== 1'b0) begin
      errs++;
      $display("[FAIL] %0d ns reconfig outputs not idle after reset", $time);
    end
    report_test("reset", e0);

    e0 = errs;
    drive_stream(12, 1'b1, 1'b0);                     // let the fifos prime
    @(posedge clk_in);
    tx_datain <= marker_word;
    drive_stream(STREAM_LEN, 1'b1, 1'b0);
    repeat (24) @(posedge clk_in);
    if (rx_lat < 0) begin
      errs++;
      $display("marker word never came back on rx_dataout");
    end
    report_test("loopback", e0);
    $display("test %-14s %0d errors, latency tx %0d rx %0d", "tx bit order", tx_errs,
             tx_lat, rx_lat);

    e0 = errs;
    drive_stream(4, 1'b1, 1'b0);
    drive_stream(8, 1'b1, 1'b1);                      // one edge, then held high
    drive_stream(8, 1'b1, 1'b0);
    repeat (rx_lat + 4) @(posedge clk_in);
    report_test("error inject", e0);

    e0 = errs;
    drive_stream(STREAM_LEN, 1'b0, 1'b0);             // far-end words
    repeat (rx_lat + 4) @(posedge clk_in);
    report_test("far-end rx", e0);

    e0 = errs;
    setting = pack_setting(4'($urandom), 3'($urandom), 5'($urandom), 5'($urandom),
                           5'($urandom), 3'($urandom));
    @(posedge clk_in);
    new_analog_params <= setting;
    @(posedge clk_in);
    wr_analog <= 1'b1;
    wait_busy(1'b1);                                  // write accepted
    @(posedge clk_in);
    wr_analog <= 1'b0;
    wait_busy(1'b0);
    wait_busy(1'b1);                                  // read-back
    wait_busy(1'b0);
    repeat (RECO_WAIT + 4) @(negedge clk_in);
    checks++;
    if (analog_params !== setting) begin
      errs++;
      $display("[FAIL] %0d ns analog_params %h, expected %h", $time, analog_params, setting);
    end
    report_test("analog write", e0);

    e0 = errs;
    @(posedge clk_in);
    rd_analog <= 1'b1;
    wait_busy(1'b1);
    @(posedge clk_in);
    rd_analog <= 1'b0;
    wait_busy(1'b0);
    repeat (RECO_WAIT + 4) @(negedge clk_in);
    checks++;
    if (analog_params !== setting) begin
      errs++;
      $display("[FAIL] %0d ns analog_params %h after read, expected %h", $time,
               analog_params, setting);
    end
    report_test("analog read", e0);

    if (prop_failed !== '0) begin
      errs++;
      $display("a bound assertion failed in the controller or a fifo");
    end

    $display("checks %0d, errors %0d", checks, errs);
    if (errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- verification/hsio_bank_properties.sv
`timescale 1ns/10ps

module hsio_bank_properties (
  input logic                 clk_in,
  input logic                 tx_lane_arst,
  input logic                 reco_write,
  input logic                 reco_read,
  input logic                 write_window,  // controller just left write_gx
  input logic                 read_window,   // controller just left read_gx
  input logic                 purge,
  input hsio_pkg::lane_word_t q
);

  int fail_cnt = 0;  // assertions failed so far

  ////////////////////////////////////////////////////////////
  // reconfiguration strobes
  ////////////////////////////////////////////////////////////
  a_write_pulse: assert property (@(posedge clk_in) disable iff (tx_lane_arst)
    reco_write |=> !reco_write)
    else begin
      $error("reco_write high for more than one cycle");
      fail_cnt++;
    end

  a_read_pulse: assert property (@(posedge clk_in) disable iff (tx_lane_arst)
    reco_read |=> !reco_read)
    else begin
      $error("reco_read high for more than one cycle");
      fail_cnt++;
    end

  // a strobe only follows its own command state
  a_write_seq: assert property (@(posedge clk_in) disable iff (tx_lane_arst)
    reco_write |-> write_window)
    else begin
      $error("reco_write outside the write sequence");
      fail_cnt++;
    end

  a_read_seq: assert property (@(posedge clk_in) disable iff (tx_lane_arst)
    reco_read |-> read_window)
    else begin
      $error("reco_read outside the read sequence");
      fail_cnt++;
    end

  // purged buffer shows zero from the next edge on
  a_purge_zero: assert property (@(posedge clk_in) disable iff (tx_lane_arst)
    purge |=> q == '0)
    else begin
      $error("fifo output not zero during purge");
      fail_cnt++;
    end

endmodule

//--- verification/hsio_clock_gen.sv
`timescale 1ns/10ps

module hsio_clock_gen #(
  parameter real period_ns  = 20.0,
  parameter int  rst_cycles = 8
) (
  output logic clk_in,
  output logic tx_lane_arst,
  output logic tx_lane_arst_early  // drops one cycle ahead of tx_lane_arst
);

  initial begin
    clk_in = 1'b0;
    forever #(period_ns / 2.0) clk_in = ~clk_in;
  end

  // both resets high from time 0
  initial begin
    tx_lane_arst       = 1'b1;
    tx_lane_arst_early = 1'b1;
    repeat (rst_cycles - 1) @(posedge clk_in);
    tx_lane_arst_early <= 1'b0;
    @(posedge clk_in);
    tx_lane_arst <= 1'b0;  // released after rst_cycles edges
  end

endmodule

//--- hw/hsio_bank.sv
`timescale 1ns/10ps

module hsio_bank #(
  parameter int lanes            = hsio_pkg::LANES,
  parameter int reco_wait_cycles = 64,
  parameter int pma_busy_cycles  = 16
) (
  input  logic                             clk_in,
  input  logic                             tx_lane_arst,
  input  logic                             tx_lane_arst_early,  // one cycle ahead of tx_lane_arst
  input  hsio_pkg::lane_word_t [lanes-1:0] tx_datain,
  input  hsio_pkg::lane_word_t [lanes-1:0] rx_lane_data,
  input  logic                             serial_loopback,
  input  logic                             tx_error_inject,
  input  logic                             wr_analog,
  input  logic                             rd_analog,
  input  hsio_pkg::analog_word_t           new_analog_params,
  output hsio_pkg::lane_word_t [lanes-1:0] tx_lane_data,
  output hsio_pkg::lane_word_t [lanes-1:0] rx_dataout,
  output logic                             reco_busy,
  output hsio_pkg::analog_word_t           analog_params
);

  import hsio_pkg::*;

  lane_word_t [lanes-1:0] tx_word;    // tx path to tx fifos
  lane_word_t [lanes-1:0] tx_fifo_q;  // tx fifos to transceiver
  lane_word_t [lanes-1:0] rx_words;   // transceiver to rx path
  logic                   purge_tx;
  logic                   reco_write;
  logic                   reco_read;
  logic                   reco_valid;
  analog_word_t           reco_params;
  analog_word_t           readback_params;

  ////////////////////////////////////////////////////////////
  // transmit side
  ////////////////////////////////////////////////////////////
  hsio_tx_path #(.lanes(lanes)) u_tx_path (
    .clk_in, .tx_lane_arst, .tx_lane_arst_early, .tx_datain, .tx_error_inject,
    .tx_word, .purge_tx
  );

  for (genvar l = 0; l < lanes; l++) begin : g_txf
    lane_phase_fifo u_txf (
      .clk_in       (clk_in),
      .tx_lane_arst (tx_lane_arst),
      .purge        (purge_tx),
      .data         (tx_word[l]),
      .q            (tx_fifo_q[l])
    );
  end

  // transceiver, reconfig and receive side
  pma_lane_model #(.lanes(lanes), .pma_busy_cycles(pma_busy_cycles)) u_pma (
    .clk_in, .tx_lane_arst, .tx_words(tx_fifo_q), .rx_lane_data, .serial_loopback,
    .reco_write, .reco_read, .reco_params, .tx_lane_data, .rx_words, .reco_busy,
    .reco_valid, .readback_params
  );

  hsio_rx_path #(.lanes(lanes)) u_rx_path (
    .clk_in, .tx_lane_arst, .rx_words, .rx_dataout
  );

  analog_reconfig_ctrl #(.reco_wait_cycles(reco_wait_cycles)) u_reco (
    .clk_in, .tx_lane_arst, .wr_analog, .rd_analog, .new_analog_params, .reco_busy,
    .reco_valid, .readback_params, .reco_write, .reco_read, .reco_params, .analog_params
  );

endmodule

//--- hw/analog_reconfig_ctrl.sv
`timescale 1ns/10ps

module analog_reconfig_ctrl #(
  parameter int reco_wait_cycles = 64
) (
  input  logic                   clk_in,
  input  logic                   tx_lane_arst,
  input  logic                   wr_analog,          // rising edge starts write + read-back
  input  logic                   rd_analog,          // rising edge starts read-back only
  input  hsio_pkg::analog_word_t new_analog_params,  // stable before wr_analog rises
  input  logic                   reco_busy,
  input  logic                   reco_valid,
  input  hsio_pkg::analog_word_t readback_params,
  output logic                   reco_write,
  output logic                   reco_read,
  output hsio_pkg::analog_word_t reco_params,
  output hsio_pkg::analog_word_t analog_params
);

  import hsio_pkg::*;

  localparam int TMR_W = $clog2(reco_wait_cycles + 1);

  reco_state_t      state;
  logic             wr_sync;
  logic             wr_last;
  logic             rd_sync;
  logic             rd_last;
  logic             wr_edge;
  logic             rd_edge;
  logic             busy_q;      // registered busy from the transceiver
  logic [TMR_W-1:0] timer;       // counts only in the wait states
  logic             timer_done;

  assign wr_edge    = wr_sync & ~wr_last;
  assign rd_edge    = rd_sync & ~rd_last;
  assign timer_done = (timer == TMR_W'(reco_wait_cycles));

  ////////////////////////////////////////////////////////////
  // request sync and edge detect
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_in or posedge tx_lane_arst) begin
    if (tx_lane_arst) begin
      wr_sync <= 1'b0;
      wr_last <= 1'b0;
      rd_sync <= 1'b0;
      rd_last <= 1'b0;
      busy_q  <= 1'b0;
    end else begin
      wr_sync <= wr_analog;
      wr_last <= wr_sync;
      rd_sync <= rd_analog;
      rd_last <= rd_sync;
      busy_q  <= reco_busy;
    end
  end

  // wait timer, saturates and restarts on each wait state
  always_ff @(posedge clk_in or posedge tx_lane_arst) begin
    if (tx_lane_arst) begin
      timer <= '0;
    end else if (state == write_wait || state == read_wait) begin
      if (!timer_done) timer <= timer + 1'b1;
    end else begin
      timer <= '0;
    end
  end

  ////////////////////////////////////////////////////////////
  // sequence fsm
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_in or posedge tx_lane_arst) begin
    if (tx_lane_arst) begin
      state         <= idle;
      reco_write    <= 1'b0;
      reco_read     <= 1'b0;
      analog_params <= '0;
    end else begin
      reco_write <= 1'b0;  // strobes default low
      reco_read  <= 1'b0;
      case (state)
        idle: begin
          if (wr_edge)      state <= write_gx;
          else if (rd_edge) state <= read_gx;
        end
        write_gx: begin
          reco_write <= 1'b1;
          state      <= write_wait;
        end
        write_wait: begin
          if (timer_done && !busy_q) state <= read_gx;  // always read back after a write
        end
        read_gx: begin
          reco_read <= 1'b1;
          state     <= read_wait;
        end
        read_wait: begin
          if (timer_done) begin
            if (reco_valid && !busy_q) analog_params <= readback_params;
            else                       analog_params <= ANALOG_FAIL_WORD;  // read failed
            state <= idle;
          end
        end
        default: state <= idle;
      endcase
    end
  end

  // word for the transceiver, taken on the write edge
  always_ff @(posedge clk_in) begin
    if (state == idle && wr_edge) reco_params <= new_analog_params;
  end

endmodule

//--- hw/hsio_rx_path.sv
`timescale 1ns/10ps

module hsio_rx_path #(
  parameter int lanes = hsio_pkg::LANES
) (
  input  logic                             clk_in,
  input  logic                             tx_lane_arst,
  input  hsio_pkg::lane_word_t [lanes-1:0] rx_words,
  output hsio_pkg::lane_word_t [lanes-1:0] rx_dataout
);

  import hsio_pkg::*;

  lane_word_t [lanes-1:0] rx_capture;  // first capture stage
  lane_word_t [lanes-1:0] rx_stage;    // second stage, eases timing
  lane_word_t [lanes-1:0] rx_rev;      // back to msb-first order
  lane_word_t [lanes-1:0] fifo_q;
  logic [2:0]             purge_sync;  // fills with ones after reset
  logic                   purge_rx;

  ////////////////////////////////////////////////////////////
  // capture and reorder
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_in) begin
    rx_capture <= rx_words;
    rx_stage   <= rx_capture;
  end

  always_comb begin
    for (int l = 0; l < lanes; l++) begin
      rx_rev[l] = bit_reverse(rx_stage[l]);  // deserializer delivers lsb first
    end
  end

  // fifos stay purged for three cycles after reset drops
  always_ff @(posedge clk_in or posedge tx_lane_arst) begin
    if (tx_lane_arst) purge_sync <= '0;
    else              purge_sync <= {purge_sync[1:0], 1'b1};
  end

  assign purge_rx = ~purge_sync[2];

  for (genvar l = 0; l < lanes; l++) begin : g_rxf
    lane_phase_fifo u_rxf (
      .clk_in       (clk_in),
      .tx_lane_arst (tx_lane_arst),
      .purge        (purge_rx),
      .data         (rx_rev[l]),
      .q            (fifo_q[l])
    );
  end

  // re-register fifo outputs
  always_ff @(posedge clk_in or posedge tx_lane_arst) begin
    if (tx_lane_arst) rx_dataout <= '0;
    else              rx_dataout <= fifo_q;
  end

endmodule

//--- hw/pma_lane_model.sv
`timescale 1ns/10ps

module pma_lane_model #(
  parameter int lanes           = hsio_pkg::LANES,
  parameter int pma_busy_cycles = 16
) (
  input  logic                             clk_in,
  input  logic                             tx_lane_arst,
  input  hsio_pkg::lane_word_t [lanes-1:0] tx_words,
  input  hsio_pkg::lane_word_t [lanes-1:0] rx_lane_data,    // far-end words
  input  logic                             serial_loopback,
  input  logic                             reco_write,
  input  logic                             reco_read,
  input  hsio_pkg::analog_word_t           reco_params,
  output hsio_pkg::lane_word_t [lanes-1:0] tx_lane_data,
  output hsio_pkg::lane_word_t [lanes-1:0] rx_words,
  output logic                             reco_busy,
  output logic                             reco_valid,
  output hsio_pkg::analog_word_t           readback_params
);

  import hsio_pkg::*;

  localparam int CNT_W = $clog2(pma_busy_cycles + 1);

  // analog settings as the hard block keeps them
  eq_ctrl_t rx_eqctrl;
  dc_gain_t rx_eqdcgain;
  preemp_t  tx_preemp_0t;
  preemp_t  tx_preemp_1t;
  preemp_t  tx_preemp_2t;
  vod_t     tx_vodctrl;

  logic [CNT_W-1:0] busy_cnt;      // cycles left in the current access
  logic             read_pending;  // access in flight is a read

  ////////////////////////////////////////////////////////////
  // serial side
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_in or posedge tx_lane_arst) begin
    if (tx_lane_arst) tx_lane_data <= '0;
    else              tx_lane_data <= tx_words;  // launch register
  end

  // loopback taps the launched words, as the serial tx -> rx path would
  assign rx_words = serial_loopback ? tx_lane_data : rx_lane_data;

  // settings access
  always_ff @(posedge clk_in or posedge tx_lane_arst) begin
    if (tx_lane_arst) begin
      {rx_eqctrl, rx_eqdcgain, tx_preemp_0t, tx_preemp_1t, tx_preemp_2t, tx_vodctrl} <= '0;
      busy_cnt     <= '0;
      read_pending <= 1'b0;
      reco_valid   <= 1'b0;
    end else if (reco_write) begin
      {rx_eqctrl, rx_eqdcgain, tx_preemp_0t, tx_preemp_1t, tx_preemp_2t, tx_vodctrl}
        <= reco_params;
      busy_cnt     <= CNT_W'(pma_busy_cycles);
      read_pending <= 1'b0;
      reco_valid   <= 1'b0;
    end else if (reco_read) begin
      busy_cnt     <= CNT_W'(pma_busy_cycles);
      read_pending <= 1'b1;
      reco_valid   <= 1'b0;  // old data no longer valid
    end else if (busy_cnt != '0) begin
      busy_cnt <= busy_cnt - 1'b1;
      if (busy_cnt == CNT_W'(1) && read_pending) begin
        reco_valid   <= 1'b1;  // read done, held until the next strobe
        read_pending <= 1'b0;
      end
    end
  end

  assign reco_busy       = (busy_cnt != '0);
  assign readback_params = {rx_eqctrl, rx_eqdcgain, tx_preemp_0t, tx_preemp_1t,
                            tx_preemp_2t, tx_vodctrl};

endmodule

//--- hw/hsio_tx_path.sv
`timescale 1ns/10ps

module hsio_tx_path #(
  parameter int lanes = hsio_pkg::LANES
) (
  input  logic                             clk_in,
  input  logic                             tx_lane_arst,
  input  logic                             tx_lane_arst_early,
  input  hsio_pkg::lane_word_t [lanes-1:0] tx_datain,
  input  logic                             tx_error_inject,  // rising edge flips one bit per lane
  output hsio_pkg::lane_word_t [lanes-1:0] tx_word,
  output logic                             purge_tx
);

  import hsio_pkg::*;

  lane_word_t [lanes-1:0] tx_rev;  // lane words in serializer order
  logic lane_rst_q;                // lane reset, early copy delayed one cycle
  logic last_inject;               // inject input from the previous edge
  logic error_bit;                 // high for one cycle after an inject edge

  // transceiver shifts lsb first
  always_comb begin
    for (int l = 0; l < lanes; l++) begin
      tx_rev[l] = bit_reverse(tx_datain[l]);
    end
  end

  ////////////////////////////////////////////////////////////
  // lane reset and fifo purge
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_in or posedge tx_lane_arst) begin
    if (tx_lane_arst) begin
      lane_rst_q <= 1'b1;
      purge_tx   <= 1'b1;
    end else begin
      lane_rst_q <= tx_lane_arst_early;
      purge_tx   <= lane_rst_q;  // purge trails the lane reset by a cycle
    end
  end

  // inject edge detect
  always_ff @(posedge clk_in or posedge tx_lane_arst) begin
    if (tx_lane_arst) begin
      last_inject <= 1'b0;
      error_bit   <= 1'b0;
    end else if (lane_rst_q) begin
      last_inject <= 1'b0;
      error_bit   <= 1'b0;
    end else begin
      last_inject <= tx_error_inject;
      error_bit   <= tx_error_inject & ~last_inject;  // one pulse, level held high is ignored
    end
  end

  // output register, error lands on bit 0 of each lane
  always_ff @(posedge clk_in or posedge tx_lane_arst) begin
    if (tx_lane_arst) begin
      tx_word <= '0;
    end else if (lane_rst_q) begin
      tx_word <= '0;
    end else begin
      for (int l = 0; l < lanes; l++) begin
        tx_word[l] <= tx_rev[l] ^ lane_word_t'(error_bit);
      end
    end
  end

endmodule

//--- hw/lane_phase_fifo.sv
`timescale 1ns/10ps

module lane_phase_fifo (
  input  logic                 clk_in,
  input  logic                 tx_lane_arst,
  input  logic                 purge,  // synchronous empty
  input  hsio_pkg::lane_word_t data,
  output hsio_pkg::lane_word_t q
);

  import hsio_pkg::*;

  localparam int PTR_W  = $clog2(FIFO_DEPTH);
  localparam int FILL_W = $clog2(FIFO_DEPTH + 1);

  lane_word_t mem [0:FIFO_DEPTH-1];  // circular storage
  logic [PTR_W-1:0]  wr_ptr;
  logic [PTR_W-1:0]  rd_ptr;
  logic [FILL_W-1:0] fill;           // entries held, stops at the prime level
  logic              reading;        // set once primed, stays until purge

  // storage written every cycle, contents never cleared
  always_ff @(posedge clk_in) begin
    mem[wr_ptr] <= data;
  end

  ////////////////////////////////////////////////////////////
  // pointers, fill level and output
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk_in or posedge tx_lane_arst) begin
    if (tx_lane_arst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      fill    <= '0;
      reading <= 1'b0;
      q       <= '0;
    end else if (purge) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      fill    <= '0;
      reading <= 1'b0;
      q       <= '0;
    end else begin
      wr_ptr <= wr_ptr + 1'b1;  // pointer wraps, depth is a power of two
      if (reading) begin
        // one in, one out, so the fill and the delay stay put
        rd_ptr <= rd_ptr + 1'b1;
        q      <= mem[rd_ptr];
      end else begin
        fill    <= fill + 1'b1;
        reading <= (fill == FILL_W'(FIFO_PRIME - 1));  // primed after this write
        q       <= '0;
      end
    end
  end

endmodule

//--- hw/hsio_pkg.sv
package hsio_pkg;

  ////////////////////////////////////////////////////////////
  // bank geometry
  ////////////////////////////////////////////////////////////
  localparam int LANES    = 5;   // lanes in one bank
  localparam int WORD_LEN = 20;  // parallel width per lane

  typedef logic [WORD_LEN-1:0] lane_word_t;

  // analog setting fields, listed msb first as packed in the word
  typedef logic [3:0]  eq_ctrl_t;      // rx equalizer control
  typedef logic [2:0]  dc_gain_t;      // rx dc gain
  typedef logic [4:0]  preemp_t;       // one tx pre-emphasis tap
  typedef logic [2:0]  vod_t;          // tx output swing
  typedef logic [24:0] analog_word_t;  // eq, dc gain, 3 taps, swing

  localparam analog_word_t ANALOG_FAIL_WORD = 25'h07dead7;  // marker for a bad read-back

  // elastic buffer sizing, all lanes share one clock here
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PRIME = 2;  // fill level before reading starts

  typedef enum logic [2:0] {
    idle,
    write_gx,    // one-cycle write strobe
    write_wait,
    read_gx,     // one-cycle read strobe
    read_wait
  } reco_state_t;

  // lane word turned end for end, the serializer sends the lsb first
  function automatic lane_word_t bit_reverse(input lane_word_t w);
    lane_word_t r;
    for (int b = 0; b < WORD_LEN; b++) begin
      r[b] = w[WORD_LEN-1-b];
    end
    return r;
  endfunction

endpackage
